/* Makefile */
# Verilator build and run of the execute cluster testbench

SIM := obj_dir/Vtb_exec_core

.PHONY: all run clean

all: run

$(SIM): sim.f $(filter-out +%,$(shell cat sim.f))
	verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_core -f sim.f

# Passes only when the testbench prints its pass line
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* alu_unit.sv */
// Single-cycle integer ALU
// Computes one operation per cycle and keeps the result in an
// output register until writeback acknowledges it
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire logic clk,
    input  wire logic rst,
    unit_issue_if.unit issue,
    unit_wb_if.unit    wb
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] result;
    logic [4:0]      shamt;
    logic            done_r;

    assign a     = issue.payload.a;
    assign b     = issue.payload.b;
    assign shamt = b[4:0];

    always_comb begin
        case (issue.payload.op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:    result = {{(XLEN-1){1'b0}}, a < b};
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $unsigned($signed(a) >>> shamt);
            default: result = b;
        endcase
    end

    // Free when empty or when the held result leaves this cycle
    assign issue.ready = !done_r || wb.ack;

    always_ff @(posedge clk) begin
        if (rst)
            done_r <= 1'b0;
        else if (issue.valid && issue.ready)
            done_r <= 1'b1;
        else if (wb.ack)
            done_r <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (issue.valid && issue.ready) begin
            wb.id   <= issue.id;
            wb.rd   <= issue.rd;
            wb.data <= result;
        end
    end

    assign wb.done = done_r;

endmodule

`default_nettype wire

/* core_cfg_pkg.sv */
// Execute cluster configuration
// Datapath widths, register count, issue tag width and
// multiplier pipeline depth shared by every block
`default_nettype none

package core_cfg_pkg;

    // Datapath
    localparam int XLEN = 32;

    // Architectural register file
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;

    // Issue tags wrap at 2**ID_W
    localparam int ID_W = 4;

    // Default multiplier depth, overridable from the top level
    localparam int MUL_STAGES = 3;

endpackage

`default_nettype wire

/* core_types_pkg.sv */
// Execute cluster types
// Opcode constants, ALU operation encoding, register and tag
// types, and the payloads handed to each execution unit
`default_nettype none

package core_types_pkg;

    import core_cfg_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // RV32I major opcodes handled by the cluster
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    //////////////////////////////////////////////////////////////////////
    // ALU operations
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        SLTU   = 4'd6,
        SLL    = 4'd7,
        SRL    = 4'd8,
        SRA    = 4'd9,
        PASS_B = 4'd10
    } alu_op_t;

    // Register address and issue tag
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ID_W-1:0]       id_t;

    //////////////////////////////////////////////////////////////////////
    // Unit payloads
    typedef struct packed {
        alu_op_t         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } alu_inputs_t;

    typedef struct packed {
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } mul_inputs_t;

endpackage

`default_nettype wire

/* decode_issue.sv */
// Decode and issue stage
// Decodes one RV32I/MUL instruction, waits on the scoreboard,
// reads operands, tags the instruction and hands it to the ALU
// or the multiplier
`timescale 1ns/1ps
`default_nettype none

module decode_issue (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          instr_valid,
    input  wire logic [31:0]                   instr,
    output logic                               instr_ready,
    output core_types_pkg::reg_addr_t          rs1_addr,
    output core_types_pkg::reg_addr_t          rs2_addr,
    input  wire logic [core_cfg_pkg::XLEN-1:0] rs1_data,
    input  wire logic [core_cfg_pkg::XLEN-1:0] rs2_data,
    input  wire logic                          rs1_busy,
    input  wire logic                          rs2_busy,
    input  wire logic                          rd_busy,
    output logic                               set_busy,
    output core_types_pkg::reg_addr_t          set_rd,
    unit_issue_if.issuer                       alu_issue,
    unit_issue_if.issuer                       mul_issue
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            is_op;
    logic            is_op_imm;
    logic            is_lui;
    logic            is_mul;
    logic            hazard;
    logic            unit_ready;
    logic            accept;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    alu_op_t         alu_op;
    id_t             next_id;

    //////////////////////////////////////////////////////////////////////
    // Field extraction
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign set_rd   = instr[11:7];

    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_mul    = is_op && funct7 == 7'b0000001 && funct3 == 3'b000;

    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // ALU operation from funct3, bit 30 picks SUB and SRA
    always_comb begin
        alu_op = ADD;
        if (is_lui) begin
            alu_op = PASS_B;
        end else begin
            case (funct3)
                3'b000: alu_op = (is_op && instr[30]) ? SUB : ADD;
                3'b001: alu_op = SLL;
                3'b010: alu_op = SLT;
                3'b011: alu_op = SLTU;
                3'b100: alu_op = XOR;
                3'b101: alu_op = instr[30] ? SRA : SRL;
                3'b110: alu_op = OR;
                default: alu_op = AND;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Hazards and handshake
    // Sources only count where the format reads them
    assign hazard = ((is_op || is_op_imm) && rs1_busy) || (is_op && rs2_busy) || rd_busy;

    assign unit_ready  = is_mul ? mul_issue.ready : alu_issue.ready;
    assign instr_ready = unit_ready && !hazard;
    assign accept      = instr_valid && instr_ready;
    assign set_busy    = accept;

    assign alu_issue.valid      = instr_valid && !hazard && !is_mul;
    assign alu_issue.id         = next_id;
    assign alu_issue.rd         = set_rd;
    assign alu_issue.payload.op = alu_op;
    assign alu_issue.payload.a  = rs1_data;
    assign alu_issue.payload.b  = is_op ? rs2_data : (is_lui ? imm_u : imm_i);

    assign mul_issue.valid     = instr_valid && !hazard && is_mul;
    assign mul_issue.id        = next_id;
    assign mul_issue.rd        = set_rd;
    assign mul_issue.payload.a = rs1_data;
    assign mul_issue.payload.b = rs2_data;

    // Tag counter, wraps naturally
    always_ff @(posedge clk) begin
        if (rst)
            next_id <= '0;
        else if (accept)
            next_id <= next_id + 1'b1;
    end

endmodule

`default_nettype wire

/* exec_core.sv */
// Integer execute cluster top level
// Decode/issue, register file with scoreboard, ALU, pipelined
// multiplier and a single writeback port, exposed as plain ports
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
    parameter int MUL_STAGES = core_cfg_pkg::MUL_STAGES
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     instr_valid,
    input  wire logic [31:0]              instr,
    output logic                          instr_ready,
    output logic                          commit_valid,
    output core_types_pkg::id_t           commit_id,
    output core_types_pkg::reg_addr_t     commit_rd,
    output logic [core_cfg_pkg::XLEN-1:0] commit_data
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Connecting signals
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            rs1_busy;
    logic            rs2_busy;
    logic            rd_busy;
    logic            set_busy;
    reg_addr_t       set_rd;

    unit_issue_if #(.payload_t(alu_inputs_t)) alu_issue ();
    unit_issue_if #(.payload_t(mul_inputs_t)) mul_issue ();
    unit_wb_if alu_wb ();
    unit_wb_if mul_wb ();

    //////////////////////////////////////////////////////////////////////
    // Issue side
    decode_issue u_decode_issue (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_busy    (rs1_busy),
        .rs2_busy    (rs2_busy),
        .rd_busy     (rd_busy),
        .set_busy    (set_busy),
        .set_rd      (set_rd),
        .alu_issue   (alu_issue),
        .mul_issue   (mul_issue)
    );

    register_file u_register_file (
        .clk          (clk),
        .rst          (rst),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .set_busy     (set_busy),
        .set_rd       (set_rd),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_busy     (rs1_busy),
        .rs2_busy     (rs2_busy),
        .rd_busy      (rd_busy)
    );

    //////////////////////////////////////////////////////////////////////
    // Execution units and writeback
    alu_unit u_alu_unit (
        .clk   (clk),
        .rst   (rst),
        .issue (alu_issue),
        .wb    (alu_wb)
    );

    mul_unit #(.NUM_STAGES(MUL_STAGES)) u_mul_unit (
        .clk   (clk),
        .rst   (rst),
        .issue (mul_issue),
        .wb    (mul_wb)
    );

    writeback u_writeback (
        .clk          (clk),
        .rst          (rst),
        .alu_wb       (alu_wb),
        .mul_wb       (mul_wb),
        .commit_valid (commit_valid),
        .commit_id    (commit_id),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

endmodule

`default_nettype wire

/* exec_if.sv */
// Execution unit handshakes
// unit_issue_if carries one operation from issue to a unit,
// unit_wb_if carries one finished result from a unit to writeback
`timescale 1ns/1ps
`default_nettype none

interface unit_issue_if #(
    parameter type payload_t = logic
);
    import core_types_pkg::*;

    logic      valid;
    logic      ready;
    id_t       id;
    reg_addr_t rd;
    payload_t  payload;

    modport issuer (output valid, id, rd, payload, input ready);
    modport unit (input valid, id, rd, payload, output ready);

endinterface

interface unit_wb_if;
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    // Result is held by the unit until done and ack meet on an edge
    logic            done;
    logic            ack;
    id_t             id;
    reg_addr_t       rd;
    logic [XLEN-1:0] data;

    modport unit (output done, id, rd, data, input ack);
    modport arbiter (input done, id, rd, data, output ack);

endinterface

`default_nettype wire

/* mul_unit.sv */
// Pipelined multiplier
// Multiplies in the first stage and keeps the low word. The
// stage chain freezes while the last stage waits for writeback.
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
    parameter int NUM_STAGES = core_cfg_pkg::MUL_STAGES
) (
    input  wire logic clk,
    input  wire logic rst,
    unit_issue_if.unit issue,
    unit_wb_if.unit    wb
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    localparam int LAST = NUM_STAGES - 1;

    logic [XLEN-1:0]       product;
    logic                  advance;
    logic [NUM_STAGES-1:0] valid_r;
    id_t                   id_r   [NUM_STAGES];
    reg_addr_t             rd_r   [NUM_STAGES];
    logic [XLEN-1:0]       data_r [NUM_STAGES];

    // Low 32 bits only, sign does not matter here
    assign product = issue.payload.a * issue.payload.b;

    // Hold everything while an un-acked result sits at the end
    assign advance     = !(valid_r[LAST] && !wb.ack);
    assign issue.ready = advance;

    //////////////////////////////////////////////////////////////////////
    // Stage chain
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= '0;
        end else if (advance) begin
            valid_r[0] <= issue.valid;
            for (int i = 1; i < NUM_STAGES; i++) begin
                valid_r[i] <= valid_r[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            id_r[0]   <= issue.id;
            rd_r[0]   <= issue.rd;
            data_r[0] <= product;
            for (int i = 1; i < NUM_STAGES; i++) begin
                id_r[i]   <= id_r[i-1];
                rd_r[i]   <= rd_r[i-1];
                data_r[i] <= data_r[i-1];
            end
        end
    end

    assign wb.done = valid_r[LAST];
    assign wb.id   = id_r[LAST];
    assign wb.rd   = rd_r[LAST];
    assign wb.data = data_r[LAST];

endmodule

`default_nettype wire

/* register_file.sv */
// Architectural register file with busy scoreboard
// 32 registers read asynchronously, x0 held at zero. A busy bit
// is set when an instruction issues to rd and cleared at commit.
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire core_types_pkg::reg_addr_t     rs1_addr,
    input  wire core_types_pkg::reg_addr_t     rs2_addr,
    input  wire logic                          set_busy,
    input  wire core_types_pkg::reg_addr_t     set_rd,
    input  wire logic                          commit_valid,
    input  wire core_types_pkg::reg_addr_t     commit_rd,
    input  wire logic [core_cfg_pkg::XLEN-1:0] commit_data,
    output logic [core_cfg_pkg::XLEN-1:0]      rs1_data,
    output logic [core_cfg_pkg::XLEN-1:0]      rs2_data,
    output logic                               rs1_busy,
    output logic                               rs2_busy,
    output logic                               rd_busy
);
    import core_cfg_pkg::*;

    logic [XLEN-1:0]     regs [NUM_REGS];
    logic [NUM_REGS-1:0] busy;

    // Register writes from the commit port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid && commit_rd != '0) begin
            regs[commit_rd] <= commit_data;
        end
    end

    // Scoreboard bits, never set for x0
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (commit_valid)
                busy[commit_rd] <= 1'b0;
            if (set_busy && set_rd != '0)
                busy[set_rd] <= 1'b1;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    assign rs1_busy = busy[rs1_addr];
    assign rs2_busy = busy[rs2_addr];
    assign rd_busy  = busy[set_rd];

endmodule

`default_nettype wire

/* sim.f */
core_cfg_pkg.sv
core_types_pkg.sv
exec_if.sv
register_file.sv
decode_issue.sv
alu_unit.sv
mul_unit.sv
writeback.sv
exec_core.sv
tb_exec_core.sv

/* tb_exec_core.sv */
// Testbench for the integer execute cluster
// Feeds directed and LFSR-driven instruction streams, keeps an
// in-order reference model indexed by issue tag and checks every
// commit against it with concurrent assertions
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;
    import core_types_pkg::*;

    localparam int NUM_TAGS    = 1 << $bits(id_t);
    localparam int ISSUE_LIMIT = 100;
    localparam int DRAIN_LIMIT = 400;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        commit_valid;
    id_t         commit_id;
    reg_addr_t   commit_rd;
    logic [31:0] commit_data;

    // Reference model state with one entry per tag
    logic [31:0] model_regs [32];
    reg_addr_t   exp_rd     [NUM_TAGS];
    logic [31:0] exp_data   [NUM_TAGS];
    int          issued_cnt [NUM_TAGS];
    int          done_cnt   [NUM_TAGS];
    id_t         model_tag;
    int          accepted;
    int          commits;
    int          mismatches;
    int          other_errors;
    logic        issue_stuck;
    logic [31:0] lfsr_state;

    exec_core u_exec_core (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .commit_valid (commit_valid),
        .commit_id    (commit_id),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Commit checks
    a_commit_known: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> issued_cnt[commit_id] > done_cnt[commit_id])
        else begin
            other_errors++;
            $display("ERROR at %0t: commit for tag %0d that is not outstanding",
                     $time, $sampled(commit_id));
        end

    a_commit_rd: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_rd == exp_rd[commit_id])
        else begin
            mismatches++;
            $display("MISMATCH at %0t: tag %0d wrote x%0d, expected x%0d", $time,
                     $sampled(commit_id), $sampled(commit_rd), exp_rd[$sampled(commit_id)]);
        end

    a_commit_data: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_data == exp_data[commit_id])
        else begin
            mismatches++;
            $display("MISMATCH at %0t: tag %0d data %08h, expected %08h", $time,
                     $sampled(commit_id), $sampled(commit_data),
                     exp_data[$sampled(commit_id)]);
        end

    // Commits seen per tag
    always @(posedge clk) begin
        if (rst) begin
            commits <= 0;
            for (int i = 0; i < NUM_TAGS; i++)
                done_cnt[i] <= 0;
        end else if (commit_valid) begin
            done_cnt[commit_id] <= done_cnt[commit_id] + 1;
            commits             <= commits + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers and encodings
    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = ^(lfsr_state & 32'h80200003);
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3,
                                          input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                          input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // Mix of R-type, I-type, LUI and MUL over x0..x15
    function automatic logic [31:0] random_instr();
        logic [31:0] kind;
        logic [31:0] f;
        logic [31:0] alt;
        logic [31:0] r;
        logic [31:0] v;
        logic [11:0] imm;
        logic [6:0]  f7;
        kind = take_bits(3);
        f    = take_bits(3);
        alt  = take_bits(1);
        r    = take_bits(12);
        v    = take_bits(20);
        f7   = (alt[0] && (f[2:0] == 3'd0 || f[2:0] == 3'd5)) ? 7'h20 : 7'h00;
        case (kind[2:0])
            3'd0, 3'd1, 3'd2:
                return enc_r(f7, {1'b0, r[11:8]}, {1'b0, r[7:4]}, f[2:0], {1'b0, r[3:0]});
            3'd3, 3'd4: begin
                imm = v[11:0];
                if (f[2:0] == 3'd1)
                    imm = {7'h00, v[4:0]};
                if (f[2:0] == 3'd5)
                    imm = {(alt[0] ? 7'h20 : 7'h00), v[4:0]};
                return enc_i(imm, {1'b0, r[7:4]}, f[2:0], {1'b0, r[3:0]});
            end
            3'd5:
                return enc_u(v[19:0], {1'b0, r[3:0]});
            default:
                return enc_r(7'h01, {1'b0, r[11:8]}, {1'b0, r[7:4]}, 3'b000, {1'b0, r[3:0]});
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model following RV32I and the MUL low word
    function automatic logic [31:0] model_result(input logic [31:0] word);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        opc = word[6:0];
        f3  = word[14:12];
        alt = word[30];
        a   = model_regs[word[19:15]];
        b   = (opc == OPC_OP) ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        sh  = b[4:0];
        if (opc == OPC_LUI)
            return {word[31:12], 12'h000};
        if (opc == OPC_OP && word[31:25] == 7'h01)
            return a * b;
        case (f3)
            3'd0: return (opc == OPC_OP && alt) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic report_error(input string msg);
        other_errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic finish_run(input logic timed_out);
        $display("Done: %0d accepted, %0d committed, %0d mismatches, %0d other errors",
                 accepted, commits, mismatches, other_errors);
        if (!timed_out && mismatches == 0 && other_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    endtask

    task automatic model_accept(input logic [31:0] word);
        id_t tag;
        tag = model_tag;
        assert (issued_cnt[tag] == done_cnt[tag])
            else report_error($sformatf("tag %0d reused while still outstanding", tag));
        exp_rd[tag]   = word[11:7];
        exp_data[tag] = model_result(word);
        if (word[11:7] != 5'd0)
            model_regs[word[11:7]] = exp_data[tag];
        issued_cnt[tag]++;
        model_tag = tag + 1'b1;
        accepted++;
    endtask

    // Present one instruction until it is taken
    task automatic send_instr(input logic [31:0] word);
        int waited;
        waited = 0;
        if (!issue_stuck) begin
            instr_valid = 1'b1;
            instr       = word;
            @(negedge clk);
            while (instr_ready !== 1'b1 && waited < ISSUE_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (instr_ready !== 1'b1) begin
                report_error($sformatf("instruction %08h not accepted within %0d cycles",
                                       word, ISSUE_LIMIT));
                issue_stuck = 1'b1;
            end else begin
                @(posedge clk);
                model_accept(word);
                #1;
                instr_valid = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        logic [31:0] v;
        logic [11:0] imm;
        int          waited;
        clk          = 1'b0;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        lfsr_state   = 32'h0129c766;
        model_tag    = '0;
        accepted     = 0;
        mismatches   = 0;
        other_errors = 0;
        issue_stuck  = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            issued_cnt[i] = 0;
            exp_rd[i]     = '0;
            exp_data[i]   = '0;
        end

        repeat (5) begin
            @(posedge clk);
            #1;
            assert (commit_valid === 1'b0) else report_error("commit_valid high during reset");
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        assert (commit_valid === 1'b0) else report_error("commit_valid high after reset");
        assert (instr_ready === 1'b1) else report_error("instr_ready low after reset");

        // ALU register and immediate forms plus LUI
        send_instr(enc_u(20'hdead5, 5'd1));
        send_instr(enc_u(20'h0f0f1, 5'd2));
        send_instr(enc_i(12'hff3, 5'd0, 3'b000, 5'd3));
        for (int i = 0; i < 8; i++)
            send_instr(enc_r(7'h00, 5'd2, 5'd1, i[2:0], 5'(16 + i)));
        send_instr(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd24));
        send_instr(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd25));
        for (int i = 0; i < 8; i++) begin
            imm = (i == 1 || i == 5) ? 12'h00b : 12'h9a5;
            send_instr(enc_i(imm, 5'd3, i[2:0], 5'(8 + i)));
        end
        send_instr(enc_i(12'h40b, 5'd1, 3'b101, 5'd26));

        // Random operands and back-to-back MULs
        for (int i = 4; i < 8; i++) begin
            v = take_bits(32);
            send_instr(enc_u(v[31:12], 5'(i)));
            send_instr(enc_i(v[11:0], 5'(i), 3'b000, 5'(i)));
        end
        send_instr(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd27));
        send_instr(enc_r(7'h01, 5'd5, 5'd4, 3'b000, 5'd28));
        send_instr(enc_r(7'h01, 5'd7, 5'd6, 3'b000, 5'd29));
        send_instr(enc_r(7'h01, 5'd4, 5'd3, 3'b000, 5'd30));

        // Dependent chain across both units
        send_instr(enc_r(7'h01, 5'd28, 5'd27, 3'b000, 5'd9));
        send_instr(enc_r(7'h00, 5'd29, 5'd9, 3'b000, 5'd10));
        send_instr(enc_r(7'h01, 5'd30, 5'd10, 3'b000, 5'd11));
        send_instr(enc_r(7'h20, 5'd9, 5'd11, 3'b000, 5'd12));
        send_instr(enc_r(7'h00, 5'd10, 5'd12, 3'b101, 5'd13));
        send_instr(enc_r(7'h01, 5'd12, 5'd13, 3'b000, 5'd9));
        send_instr(enc_i(12'h5a5, 5'd9, 3'b100, 5'd14));

        // x0 as destination and then as source
        send_instr(enc_i(12'h005, 5'd1, 3'b000, 5'd0));
        send_instr(enc_r(7'h01, 5'd5, 5'd4, 3'b000, 5'd0));
        send_instr(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd15));
        send_instr(enc_r(7'h00, 5'd6, 5'd0, 3'b011, 5'd31));

        // Mixed random stream
        repeat (200)
            send_instr(random_instr());

        if (issue_stuck) begin
            finish_run(1'b1);
        end else begin
            waited = 0;
            while (commits != accepted && waited < DRAIN_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (commits != accepted) begin
                report_error($sformatf("only %0d of %0d instructions committed",
                                       commits, accepted));
                finish_run(1'b1);
            end else begin
                // Idle a few cycles so a stray extra commit would show
                repeat (3) @(posedge clk);
                #1;
                for (int i = 0; i < NUM_TAGS; i++) begin
                    assert (issued_cnt[i] == done_cnt[i])
                        else report_error($sformatf("tag %0d issued %0d times, committed %0d",
                                                    i, issued_cnt[i], done_cnt[i]));
                end
                finish_run(1'b0);
            end
        end
    end

endmodule

`default_nettype wire

/* writeback.sv */
// Writeback arbiter
// Picks one finished unit result per cycle, multiplier first,
// and registers it onto the commit port
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  wire logic                     clk,
    input  wire logic                     rst,
    unit_wb_if.arbiter                    alu_wb,
    unit_wb_if.arbiter                    mul_wb,
    output logic                          commit_valid,
    output core_types_pkg::id_t           commit_id,
    output core_types_pkg::reg_addr_t     commit_rd,
    output logic [core_cfg_pkg::XLEN-1:0] commit_data
);

    logic pick_mul;

    // Multiplier first so its stalled pipeline drains
    assign pick_mul = mul_wb.done;

    assign mul_wb.ack = mul_wb.done;
    assign alu_wb.ack = alu_wb.done && !pick_mul;

    always_ff @(posedge clk) begin
        if (rst)
            commit_valid <= 1'b0;
        else
            commit_valid <= mul_wb.done || alu_wb.done;
    end

    always_ff @(posedge clk) begin
        if (pick_mul) begin
            commit_id   <= mul_wb.id;
            commit_rd   <= mul_wb.rd;
            commit_data <= mul_wb.data;
        end else begin
            commit_id   <= alu_wb.id;
            commit_rd   <= alu_wb.rd;
            commit_data <= alu_wb.data;
        end
    end

endmodule

`default_nettype wire
